/* sources.f */
logic/brew_ctrl_pkg.sv
logic/machine_io_pkg.sv
logic/brew_sequencer.sv
logic/dwell_timer.sv
logic/recipe_handshake.sv
logic/status_decoder.sv
logic/coffee_main_ctrl.sv
verif/coffee_main_ctrl_sva.sv
verif/coffee_main_ctrl_tb.sv

/* Bender.yml */
package:
  name: coffee_main_ctrl

sources:
  - logic/brew_ctrl_pkg.sv
  - logic/machine_io_pkg.sv
  - logic/brew_sequencer.sv
  - logic/dwell_timer.sv
  - logic/recipe_handshake.sv
  - logic/status_decoder.sv
  - logic/coffee_main_ctrl.sv
  - target: test
    files:
      - verif/coffee_main_ctrl_sva.sv
      - verif/coffee_main_ctrl_tb.sv

/* verif/coffee_main_ctrl_tb.sv */
// Directed testbench for the coffee machine main controller, run as top with the bound checks
module coffee_main_ctrl_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD = 100;
    localparam int INIT_N     = int'(brew_ctrl_pkg::INIT_CYCLES);
    localparam int COOL_N     = int'(brew_ctrl_pkg::COOLDOWN_CYCLES);
    localparam int TIMEOUT_N  = int'(brew_ctrl_pkg::COMPLETE_TIMEOUT_CYCLES);
    // Reset, boot, errors, brew, abort, stop plus timeout, maintenance, margin
    localparam int WATCHDOG_CYCLES = 10 + (INIT_N + 10) + 60 + 80 + (COOL_N + 60)
                                     + (TIMEOUT_N + 120) + 30 + 100;

    typedef enum {FLD_READY, FLD_ACTIVE, FLD_FAULT, FLD_HEAT, FLD_ERR_CYCLE,
                  FLD_SERVICE, FLD_STAGE, FLD_START} field_t;

    logic                            clk;
    logic                            rst_n;
    machine_io_pkg::menu_cmd_t       menu;
    machine_io_pkg::fault_status_t   faults;
    machine_io_pkg::water_status_t   water;
    machine_io_pkg::recipe_status_t  recipe;
    logic                            recipe_start;
    logic                            recipe_abort;
    machine_io_pkg::machine_status_t status;

    int          errors = 0;
    int          checks = 0;
    int          abort_count = 0;
    logic [31:0] rng_state = 32'd28;

    coffee_main_ctrl dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .menu         (menu),
        .faults       (faults),
        .water        (water),
        .recipe       (recipe),
        .recipe_start (recipe_start),
        .recipe_abort (recipe_abort),
        .status       (status)
    );

    // ==============================
    // Clock, watchdog, monitors
    // ==============================

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, a test never finished", WATCHDOG_CYCLES);
        $display("SOME TESTS FAILED");
        $finish;
    end

    // Abort strobes seen by the engine
    always @(posedge clk) begin
        if (rst_n && recipe_abort)
            abort_count <= abort_count + 1;
    end

    // ==============================
    // Helpers
    // ==============================

    function automatic logic [31:0] next_random(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int field_value(input field_t f);
        case (f)
            FLD_READY:     return int'(status.ready);
            FLD_ACTIVE:    return int'(status.active);
            FLD_FAULT:     return int'(status.fault);
            FLD_HEAT:      return int'(status.heating_enable);
            FLD_ERR_CYCLE: return int'(status.error_cycle_enable);
            FLD_SERVICE:   return int'(status.service_timer_enable);
            FLD_STAGE:     return int'(status.brew_stage);
            default:       return int'(recipe_start);
        endcase
    endfunction

    // Four-state compare so an unknown output never passes
    task automatic check_value(input string test, input string what,
                               input integer expected, input integer actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %s: %s expected %0d actual %0d", test, what, expected, actual);
        end
    endtask

    task automatic check_range(input string test, input string what,
                               input int lo, input int hi, input int actual);
        checks++;
        if (actual < lo || actual > hi) begin
            errors++;
            $display("[FAIL] %s: %s expected %0d..%0d actual %0d", test, what, lo, hi, actual);
        end
    endtask

    // Samples on the falling edge and returns the cycles waited
    task automatic await_field(input string test, input field_t f, input int val,
                               input int limit, output int cycles);
        cycles = 0;
        @(negedge clk);
        while (field_value(f) != val && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        checks++;
        if (field_value(f) != val) begin
            errors++;
            $display("%s: timed out after %0d cycles waiting for %s to become %0d",
                     test, limit, f.name(), val);
        end
    endtask

    task automatic press_start();
        @(posedge clk);
        menu.start <= 1'b1;
        @(posedge clk);
        menu.start <= 1'b0;
    endtask

    // From splash through idle and heating into brewing with the engine still idle
    task automatic enter_brewing(input string test);
        int cycles;
        @(posedge clk);
        menu.screen <= 4'd2;
        press_start();
        await_field(test, FLD_READY, 1, 6, cycles);
        press_start();
        await_field(test, FLD_START, 1, 8, cycles);
    endtask

    // ==============================
    // Tests
    // ==============================

    task automatic test_reset_boot();
        string name = "reset_boot";
        int    cycles;
        repeat (4) @(posedge clk);
        @(negedge clk);
        check_value(name, "status in reset", 0, status);
        check_value(name, "recipe_start in reset", 0, recipe_start);
        check_value(name, "recipe_abort in reset", 0, recipe_abort);
        @(posedge clk);
        rst_n <= 1'b1;
        await_field(name, FLD_ACTIVE, 1, 3, cycles);
        check_value(name, "service timer in boot", 0, status.service_timer_enable);
        // Splash shows as active low
        await_field(name, FLD_ACTIVE, 0, INIT_N + 4, cycles);
        check_range(name, "boot cycles", INIT_N - 2, INIT_N + 2, cycles);
        check_value(name, "service timer at splash", 1, status.service_timer_enable);
    endtask

    task automatic test_error_cycling();
        string      name = "error_cycling";
        int         cycles;
        logic [3:0] count;
        rng_state = next_random(rng_state);
        count = rng_state[3:0];
        if (count == 4'd0)
            count = 4'd1;
        @(posedge clk);
        faults.warnings <= count;
        await_field(name, FLD_ERR_CYCLE, 1, 4, cycles);
        check_value(name, "fault with warnings only", 0, status.fault);
        @(posedge clk);
        faults.warnings <= 4'd0;
        await_field(name, FLD_ERR_CYCLE, 0, 4, cycles);
        check_value(name, "service timer back at splash", 1, status.service_timer_enable);
        @(posedge clk);
        faults.critical <= 1'b1;
        await_field(name, FLD_FAULT, 1, 4, cycles);
        // Start must not pass a critical error
        press_start();
        repeat (3) @(negedge clk);
        check_value(name, "ready after start with critical", 0, status.ready);
        check_value(name, "error cycling with critical", 1, status.error_cycle_enable);
        @(posedge clk);
        faults.critical <= 1'b0;
        menu.start      <= 1'b1;
        menu.screen     <= 4'd2;
        @(posedge clk);
        menu.start <= 1'b0;
        await_field(name, FLD_READY, 1, 4, cycles);
        check_value(name, "error cycling in idle", 0, status.error_cycle_enable);
    endtask

    task automatic test_heated_brew();
        string name = "heated_brew";
        int    cycles;
        int    aborts;
        aborts = abort_count;
        press_start();
        await_field(name, FLD_HEAT, 1, 4, cycles);
        check_value(name, "temp_mode", int'(brew_ctrl_pkg::TEMP_BREWING), status.temp_mode);
        check_value(name, "stage heating", int'(brew_ctrl_pkg::STAGE_HEATING),
                    status.brew_stage);
        @(posedge clk);
        recipe.valid         <= 1'b1;
        water.temp_ready     <= 1'b1;
        water.pressure_ready <= 1'b1;
        await_field(name, FLD_START, 1, 6, cycles);
        // Request holds while the engine is silent
        repeat (3) begin
            @(negedge clk);
            check_value(name, "recipe_start held", 1, recipe_start);
        end
        @(posedge clk);
        recipe.active <= 1'b1;
        await_field(name, FLD_START, 0, 3, cycles);
        await_field(name, FLD_STAGE, int'(brew_ctrl_pkg::STAGE_BREWING), 4, cycles);
        @(posedge clk);
        recipe.complete <= 1'b1;
        recipe.active   <= 1'b0;
        await_field(name, FLD_STAGE, int'(brew_ctrl_pkg::STAGE_COMPLETE), 4, cycles);
        check_value(name, "heating on complete screen", 1, status.heating_enable);
        @(posedge clk);
        recipe.complete <= 1'b0;
        press_start();
        await_field(name, FLD_HEAT, 0, 4, cycles);
        check_value(name, "stage at splash", int'(brew_ctrl_pkg::STAGE_NONE), status.brew_stage);
        check_value(name, "abort pulses", aborts, abort_count);
    endtask

    task automatic test_abort_brew();
        string name = "abort_brew";
        int    cycles;
        int    aborts;
        aborts = abort_count;
        enter_brewing(name);
        @(posedge clk);
        menu.screen <= machine_io_pkg::MENU_ABORT_CONFIRM;
        // Cooldown keeps active high with the heater off
        await_field(name, FLD_HEAT, 0, 4, cycles);
        check_value(name, "active in cooldown", 1, status.active);
        await_field(name, FLD_ACTIVE, 0, COOL_N + 10, cycles);
        check_range(name, "cooldown cycles", COOL_N - 2, COOL_N + 2, cycles);
        check_value(name, "abort pulses", aborts + 1, abort_count);
        check_value(name, "recipe_start after abort", 0, recipe_start);
        @(posedge clk);
        menu.screen <= machine_io_pkg::MENU_SPLASH;
    endtask

    task automatic test_unexpected_stop();
        string name = "unexpected_stop";
        int    cycles;
        int    aborts;
        aborts = abort_count;
        enter_brewing(name);
        @(posedge clk);
        recipe.active <= 1'b1;
        await_field(name, FLD_START, 0, 3, cycles);
        // Engine drops out without reporting complete
        @(posedge clk);
        recipe.active <= 1'b0;
        await_field(name, FLD_ERR_CYCLE, 1, 4, cycles);
        check_value(name, "abort pulses", aborts + 1, abort_count);
        check_value(name, "fault without critical", 0, status.fault);
        await_field(name, FLD_ERR_CYCLE, 0, 4, cycles);
    endtask

    task automatic test_complete_timeout();
        string name = "complete_timeout";
        int    cycles;
        int    aborts;
        aborts = abort_count;
        enter_brewing(name);
        @(posedge clk);
        recipe.active <= 1'b1;
        await_field(name, FLD_START, 0, 3, cycles);
        @(posedge clk);
        recipe.complete <= 1'b1;
        recipe.active   <= 1'b0;
        await_field(name, FLD_STAGE, int'(brew_ctrl_pkg::STAGE_COMPLETE), 4, cycles);
        // No start, so only the timeout leaves the screen
        await_field(name, FLD_STAGE, int'(brew_ctrl_pkg::STAGE_NONE), TIMEOUT_N + 10, cycles);
        check_range(name, "complete screen cycles", TIMEOUT_N - 2, TIMEOUT_N + 2, cycles);
        check_value(name, "abort pulses", aborts, abort_count);
        @(posedge clk);
        recipe.complete <= 1'b0;
    endtask

    task automatic test_maintenance();
        string name = "maintenance";
        int    cycles;
        @(posedge clk);
        menu.maintenance <= 1'b1;
        menu.screen      <= machine_io_pkg::MENU_MAINTENANCE;
        await_field(name, FLD_SERVICE, 0, 4, cycles);
        check_value(name, "active in maintenance", 0, status.active);
        @(posedge clk);
        menu.maintenance <= 1'b0;
        menu.screen      <= machine_io_pkg::MENU_SPLASH;
        await_field(name, FLD_SERVICE, 1, 4, cycles);
        check_value(name, "ready at splash", 0, status.ready);
        check_value(name, "error cycling at splash", 0, status.error_cycle_enable);
    endtask

    // ==============================
    // Main sequence
    // ==============================

    initial begin
        rst_n  = 1'b0;
        menu   = '0;
        faults = '0;
        water  = '0;
        recipe = '0;
        test_reset_boot();
        test_error_cycling();
        test_heated_brew();
        test_abort_brew();
        test_unexpected_stop();
        test_complete_timeout();
        test_maintenance();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

/* verif/coffee_main_ctrl_sva.sv */
// Concurrent checks on the recipe strobes and status outputs, bound into the controller blocks
module coffee_main_ctrl_sva (
    input logic clk,
    input logic rst_n,
    input logic recipe_active,
    input logic recipe_start,
    input logic recipe_abort,
    input logic ready,
    input logic active
);
    timeunit 1ns;
    timeprecision 1ps;

    // Abort is a strobe, never two cycles in a row
    abort_single_cycle: assert property (
        @(posedge clk) disable iff (!rst_n) recipe_abort |=> !recipe_abort
    ) else $error("recipe_abort held for more than one cycle");

    // A new start request only goes to an idle engine
    start_not_while_active: assert property (
        @(posedge clk) disable iff (!rst_n) $rose(recipe_start) |-> !recipe_active
    ) else $error("recipe_start rose while the recipe engine was active");

    // Ready and busy exclude each other on the display
    ready_active_exclusive: assert property (
        @(posedge clk) disable iff (!rst_n) !(ready && active)
    ) else $error("ready and active high together");

endmodule

// Handshake side, status inputs tied off
bind recipe_handshake coffee_main_ctrl_sva u_hs_sva (
    .clk           (clk),
    .rst_n         (rst_n),
    .recipe_active (recipe_active),
    .recipe_start  (recipe_start),
    .recipe_abort  (recipe_abort),
    .ready         (1'b0),
    .active        (1'b0)
);

// Status side, strobes tied off
bind status_decoder coffee_main_ctrl_sva u_status_sva (
    .clk           (clk),
    .rst_n         (rst_n),
    .recipe_active (recipe_active),
    .recipe_start  (1'b0),
    .recipe_abort  (1'b0),
    .ready         (status.ready),
    .active        (status.active)
);

/* logic/coffee_main_ctrl.sv */
// Top of the coffee machine main controller, connects sequencer, timer and output blocks
module coffee_main_ctrl (
    input  logic                            clk,
    input  logic                            rst_n,
    input  machine_io_pkg::menu_cmd_t       menu,
    input  machine_io_pkg::fault_status_t   faults,
    input  machine_io_pkg::water_status_t   water,
    input  machine_io_pkg::recipe_status_t  recipe,
    output logic                            recipe_start,
    output logic                            recipe_abort,
    output machine_io_pkg::machine_status_t status
);

    // Current controller state, fanned out to every block
    brew_ctrl_pkg::ctrl_state_t   state;
    // Dwell expiries back to the sequencer
    machine_io_pkg::dwell_flags_t dwell;
    // Engine has gone active during this brew
    logic                         recipe_started;

    // ==============================
    // State sequencing
    // ==============================

    brew_sequencer u_sequencer (
        .clk            (clk),
        .rst_n          (rst_n),
        .menu           (menu),
        .faults         (faults),
        .water          (water),
        .recipe         (recipe),
        .dwell          (dwell),
        .recipe_started (recipe_started),
        .state          (state)
    );

    dwell_timer u_dwell_timer (
        .clk   (clk),
        .rst_n (rst_n),
        .state (state),
        .dwell (dwell)
    );

    // ==============================
    // Outputs
    // ==============================

    recipe_handshake u_recipe_hs (
        .clk            (clk),
        .rst_n          (rst_n),
        .state          (state),
        .recipe_active  (recipe.active),
        .recipe_start   (recipe_start),
        .recipe_abort   (recipe_abort),
        .recipe_started (recipe_started)
    );

    status_decoder u_status (
        .clk           (clk),
        .rst_n         (rst_n),
        .state         (state),
        .critical      (faults.critical),
        .recipe_active (recipe.active),
        .status        (status)
    );

endmodule

/* logic/status_decoder.sv */
// Registered per-state status, water heating control and brew stage for the display
module status_decoder (
    input  logic                            clk,
    input  logic                            rst_n,
    input  brew_ctrl_pkg::ctrl_state_t      state,
    input  logic                            critical,
    input  logic                            recipe_active,
    output machine_io_pkg::machine_status_t status
);

    machine_io_pkg::machine_status_t status_d;

    // ==============================
    // Per-state table
    // ==============================

    always_comb begin
        // Idle defaults that each state overrides as needed
        status_d                      = '0;
        status_d.temp_mode            = brew_ctrl_pkg::TEMP_STANDBY;
        status_d.brew_stage           = brew_ctrl_pkg::STAGE_NONE;
        status_d.service_timer_enable = 1'b1;
        case (state)
            brew_ctrl_pkg::INIT: begin
                status_d.active               = 1'b1;
                status_d.service_timer_enable = 1'b0;
            end
            brew_ctrl_pkg::ERROR_CYCLE: begin
                status_d.fault              = critical;
                status_d.error_cycle_enable = 1'b1;
            end
            brew_ctrl_pkg::IDLE: begin
                status_d.ready = 1'b1;
            end
            brew_ctrl_pkg::HEATING: begin
                status_d.active     = 1'b1;
                status_d.brew_stage = brew_ctrl_pkg::STAGE_HEATING;
            end
            brew_ctrl_pkg::READY, brew_ctrl_pkg::VALIDATE: begin
                status_d.ready = 1'b1;
            end
            brew_ctrl_pkg::BREWING: begin
                status_d.active = 1'b1;
                // Stage moves only once the engine runs and holds otherwise
                if (recipe_active)
                    status_d.brew_stage = brew_ctrl_pkg::STAGE_BREWING;
                else
                    status_d.brew_stage = status.brew_stage;
            end
            brew_ctrl_pkg::COMPLETE: begin
                status_d.brew_stage = brew_ctrl_pkg::STAGE_COMPLETE;
            end
            brew_ctrl_pkg::COOLDOWN: begin
                status_d.active = 1'b1;
            end
            brew_ctrl_pkg::MAINTENANCE: begin
                // Service hours do not accrue while a technician is working
                status_d.service_timer_enable = 1'b0;
            end
            default: begin
                // SPLASH and unused codes keep the idle defaults
            end
        endcase

        // Water kept hot from heating until the completion screen ends
        if (state inside {brew_ctrl_pkg::HEATING, brew_ctrl_pkg::READY,
                          brew_ctrl_pkg::VALIDATE, brew_ctrl_pkg::BREWING,
                          brew_ctrl_pkg::COMPLETE}) begin
            status_d.heating_enable = 1'b1;
            status_d.temp_mode      = brew_ctrl_pkg::TEMP_BREWING;
        end
    end

    // ==============================
    // Output register
    // ==============================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            status            <= '0;
            status.temp_mode  <= brew_ctrl_pkg::TEMP_STANDBY;
            status.brew_stage <= brew_ctrl_pkg::STAGE_NONE;
        end else begin
            status <= status_d;
        end
    end

endmodule

/* logic/recipe_handshake.sv */
// Start and abort handshake with the recipe engine around the BREWING state
module recipe_handshake (
    input  logic                       clk,
    input  logic                       rst_n,
    input  brew_ctrl_pkg::ctrl_state_t state,
    input  logic                       recipe_active,
    output logic                       recipe_start,
    output logic                       recipe_abort,
    output logic                       recipe_started
);

    brew_ctrl_pkg::ctrl_state_t prev_state;
    logic                       started_q;
    logic                       in_brewing;
    logic                       brew_entry;
    logic                       brew_exit;

    assign in_brewing = (state == brew_ctrl_pkg::BREWING);
    assign brew_entry = in_brewing && (prev_state != brew_ctrl_pkg::BREWING);
    assign brew_exit  = !in_brewing && (prev_state == brew_ctrl_pkg::BREWING);

    // ==============================
    // Acknowledge tracking
    // ==============================

    // Flag from an earlier brew is hidden on the entry cycle
    assign recipe_started = started_q && !brew_entry;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prev_state <= brew_ctrl_pkg::INIT;
            started_q  <= 1'b0;
        end else begin
            prev_state <= state;
            if (in_brewing)
                started_q <= recipe_started | recipe_active;
        end
    end

    // ==============================
    // Engine strobes
    // ==============================

    // Request held from the first BREWING cycle until the engine goes active
    assign recipe_start = in_brewing && !recipe_started;

    // A normal finish goes to COMPLETE, anything else stops the engine
    assign recipe_abort = brew_exit && (state != brew_ctrl_pkg::COMPLETE);

endmodule

/* logic/dwell_timer.sv */
// Counts cycles spent in the current state and raises the INIT, COOLDOWN and COMPLETE expiries
module dwell_timer (
    input  logic                         clk,
    input  logic                         rst_n,
    input  brew_ctrl_pkg::ctrl_state_t   state,
    output machine_io_pkg::dwell_flags_t dwell
);

    brew_ctrl_pkg::ctrl_state_t prev_state;
    brew_ctrl_pkg::dwell_count_t count_q;
    // Count as seen by the comparators this cycle
    brew_ctrl_pkg::dwell_count_t count;
    logic                        state_changed;

    assign state_changed = (state != prev_state);
    // Zero on the first cycle of a new state
    assign count = state_changed ? '0 : count_q;

    // ==============================
    // Counter
    // ==============================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prev_state <= brew_ctrl_pkg::INIT;
            count_q    <= '0;
        end else begin
            prev_state <= state;
            // Saturate at all ones
            if (count != '1)
                count_q <= count + 1'b1;
            else
                count_q <= count;
        end
    end

    // ==============================
    // Expiry levels
    // ==============================

    always_comb begin
        dwell.init_done = (state == brew_ctrl_pkg::INIT) &&
                          (count >= brew_ctrl_pkg::INIT_CYCLES);
        dwell.cooldown_done = (state == brew_ctrl_pkg::COOLDOWN) &&
                              (count >= brew_ctrl_pkg::COOLDOWN_CYCLES);
        dwell.complete_timeout = (state == brew_ctrl_pkg::COMPLETE) &&
                                 (count >= brew_ctrl_pkg::COMPLETE_TIMEOUT_CYCLES);
    end

endmodule

/* logic/brew_sequencer.sv */
// Main controller FSM, holds the state register and applies the transition rules
module brew_sequencer (
    input  logic                           clk,
    input  logic                           rst_n,
    input  machine_io_pkg::menu_cmd_t      menu,
    input  machine_io_pkg::fault_status_t  faults,
    input  machine_io_pkg::water_status_t  water,
    input  machine_io_pkg::recipe_status_t recipe,
    input  machine_io_pkg::dwell_flags_t   dwell,
    input  logic                           recipe_started,
    output brew_ctrl_pkg::ctrl_state_t     state
);

    brew_ctrl_pkg::ctrl_state_t state_next;

    // Decoded menu conditions
    logic on_splash;
    logic on_abort;
    logic any_warning;

    assign on_splash   = (menu.screen == machine_io_pkg::MENU_SPLASH);
    assign on_abort    = (menu.screen == machine_io_pkg::MENU_ABORT_CONFIRM);
    assign any_warning = (faults.warnings != 4'd0);

    // ==============================
    // State register
    // ==============================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= brew_ctrl_pkg::INIT;
        end else begin
            state <= state_next;
        end
    end

    // ==============================
    // Next state, checks in priority order
    // ==============================

    always_comb begin
        state_next = state;
        case (state)
            brew_ctrl_pkg::INIT: begin
                if (dwell.init_done)
                    state_next = brew_ctrl_pkg::SPLASH;
            end
            brew_ctrl_pkg::SPLASH: begin
                if (menu.maintenance)
                    state_next = brew_ctrl_pkg::MAINTENANCE;
                else if (faults.critical || any_warning)
                    state_next = brew_ctrl_pkg::ERROR_CYCLE;
                else if (menu.start)
                    state_next = brew_ctrl_pkg::IDLE;
            end
            brew_ctrl_pkg::ERROR_CYCLE: begin
                // Start lets the user carry on past warnings, never past a critical error
                if (menu.maintenance)
                    state_next = brew_ctrl_pkg::MAINTENANCE;
                else if (menu.start && !faults.critical)
                    state_next = brew_ctrl_pkg::IDLE;
                else if (!faults.critical && !any_warning)
                    state_next = brew_ctrl_pkg::SPLASH;
            end
            brew_ctrl_pkg::IDLE: begin
                // Waits here while the user walks the selection screens
                if (faults.critical)
                    state_next = brew_ctrl_pkg::ERROR_CYCLE;
                else if (menu.maintenance)
                    state_next = brew_ctrl_pkg::MAINTENANCE;
                else if (menu.start)
                    state_next = water.system_ok ? brew_ctrl_pkg::READY : brew_ctrl_pkg::HEATING;
                else if (on_splash)
                    state_next = brew_ctrl_pkg::SPLASH;
            end
            brew_ctrl_pkg::HEATING: begin
                if (faults.critical)
                    state_next = brew_ctrl_pkg::ERROR_CYCLE;
                else if (on_abort)
                    state_next = brew_ctrl_pkg::COOLDOWN;
                else if (water.temp_ready && water.pressure_ready)
                    state_next = brew_ctrl_pkg::VALIDATE;
            end
            brew_ctrl_pkg::READY: begin
                if (faults.critical)
                    state_next = brew_ctrl_pkg::ERROR_CYCLE;
                else if (menu.maintenance)
                    state_next = brew_ctrl_pkg::MAINTENANCE;
                else if (menu.start && recipe.valid)
                    state_next = brew_ctrl_pkg::VALIDATE;
                else if (on_splash)
                    state_next = brew_ctrl_pkg::SPLASH;
                else if (!water.system_ok)
                    state_next = brew_ctrl_pkg::HEATING;
            end
            brew_ctrl_pkg::VALIDATE: begin
                // Single-cycle check, every branch leaves
                if (faults.critical)
                    state_next = brew_ctrl_pkg::ERROR_CYCLE;
                else if (!recipe.valid)
                    state_next = brew_ctrl_pkg::IDLE;
                else if (!water.temp_ready || !water.pressure_ready)
                    state_next = brew_ctrl_pkg::HEATING;
                else
                    state_next = brew_ctrl_pkg::BREWING;
            end
            brew_ctrl_pkg::BREWING: begin
                if (faults.critical) begin
                    state_next = brew_ctrl_pkg::ERROR_CYCLE;
                end else if (on_abort) begin
                    // Hold until the engine has actually stopped
                    if (!recipe.active)
                        state_next = brew_ctrl_pkg::COOLDOWN;
                end else if (recipe.complete && recipe_started) begin
                    state_next = brew_ctrl_pkg::COMPLETE;
                end else if (!recipe.active && recipe_started) begin
                    // Engine stopped without finishing
                    state_next = brew_ctrl_pkg::ERROR_CYCLE;
                end
            end
            brew_ctrl_pkg::COMPLETE: begin
                if (menu.start || dwell.complete_timeout)
                    state_next = brew_ctrl_pkg::SPLASH;
            end
            brew_ctrl_pkg::COOLDOWN: begin
                if (dwell.cooldown_done)
                    state_next = brew_ctrl_pkg::SPLASH;
            end
            brew_ctrl_pkg::MAINTENANCE: begin
                if (menu.screen != machine_io_pkg::MENU_MAINTENANCE)
                    state_next = brew_ctrl_pkg::SPLASH;
            end
            default: begin
                state_next = brew_ctrl_pkg::INIT;
            end
        endcase
    end

endmodule

/* logic/machine_io_pkg.sv */
// Port groups of the main controller, one packed struct per neighbouring block
package machine_io_pkg;

    // ==============================
    // Menu navigator
    // ==============================

    // Screen code from the menu navigator, only the screens we react to get names
    typedef logic [3:0] menu_screen_t;

    localparam menu_screen_t MENU_SPLASH        = 4'd0;
    localparam menu_screen_t MENU_MAINTENANCE   = 4'd9;
    localparam menu_screen_t MENU_ABORT_CONFIRM = 4'd11;

    typedef struct packed {
        menu_screen_t screen;
        // One-cycle pulse on user confirmation
        logic         start;
        // Level while the hidden menu is requested
        logic         maintenance;
    } menu_cmd_t;

    // ==============================
    // Inputs from the other blocks
    // ==============================

    // Error handler summary
    typedef struct packed {
        logic       critical;
        logic [3:0] warnings;
    } fault_status_t;

    // Water temperature controller
    typedef struct packed {
        logic system_ok;
        logic temp_ready;
        logic pressure_ready;
    } water_status_t;

    // Recipe engine progress
    typedef struct packed {
        logic active;
        logic complete;
        logic valid;
    } recipe_status_t;

    // ==============================
    // Internal and output groups
    // ==============================

    // Expiry levels from the dwell timer
    typedef struct packed {
        logic init_done;
        logic cooldown_done;
        logic complete_timeout;
    } dwell_flags_t;

    // Registered status and water control
    typedef struct packed {
        logic                     ready;
        logic                     active;
        logic                     fault;
        logic                     heating_enable;
        brew_ctrl_pkg::temp_mode_t  temp_mode;
        logic                     error_cycle_enable;
        logic                     service_timer_enable;
        brew_ctrl_pkg::brew_stage_t brew_stage;
    } machine_status_t;

endpackage

/* logic/brew_ctrl_pkg.sv */
// Controller-side definitions shared by the coffee machine main controller blocks
package brew_ctrl_pkg;

    // ==============================
    // Controller states
    // ==============================

    // Sequencer states, 11 of the 16 codes are used
    typedef enum logic [3:0] {
        INIT,
        SPLASH,
        ERROR_CYCLE,
        IDLE,
        HEATING,
        READY,
        VALIDATE,
        BREWING,
        COMPLETE,
        COOLDOWN,
        MAINTENANCE
    } ctrl_state_t;

    // ==============================
    // Dwell timer limits
    // ==============================

    // Counter width, all limits must fit below the saturation value
    localparam int DWELL_W = 8;

    typedef logic [DWELL_W-1:0] dwell_count_t;

    // Cycles of boot delay before the splash screen
    localparam dwell_count_t INIT_CYCLES = 8'd20;
    // Cycles of cooldown after an abort
    localparam dwell_count_t COOLDOWN_CYCLES = 8'd40;
    // Cycles the completion screen waits for the user
    localparam dwell_count_t COMPLETE_TIMEOUT_CYCLES = 8'd200;

    // ==============================
    // Status encodings
    // ==============================

    // Brew progress shown to the display, gaps are reserved for recipe stages
    typedef enum logic [2:0] {
        STAGE_NONE     = 3'd0,
        STAGE_HEATING  = 3'd1,
        STAGE_BREWING  = 3'd2,
        STAGE_COMPLETE = 3'd7
    } brew_stage_t;

    // Target mode for the water temperature controller
    typedef enum logic [1:0] {
        TEMP_STANDBY = 2'b00,
        TEMP_BREWING = 2'b01
    } temp_mode_t;

endpackage
